// File: rtl/router_pkg.sv
/* Shared widths, depths, typedefs and the arbiter state enum
   for the four-port packet echo router */

`default_nettype none

package router_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Ports and stream

    localparam int NUM_PORTS = 4;
    localparam int PORT_W    = 2;
    localparam int WORD_W    = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Buffering and credits

    // Ingress FIFO depth doubles as the sender's initial credit count
    localparam int ING_FIFO_DEPTH = 16;
    localparam int FIFO_AW        = $clog2(ING_FIFO_DEPTH);

    localparam int EGR_CREDITS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic [PORT_W-1:0] port_idx_t;
    typedef logic [WORD_W-1:0] word_t;

    // Holds 0 to EGR_CREDITS
    typedef logic [2:0] credit_cnt_t;

    // Extra MSB is the wrap bit
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    typedef logic [15:0] pkt_cnt_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_PACKET
    } arb_state_t;

endpackage

`default_nettype wire

// File: rtl/ingress_port_buffer.sv
/* Per-port ingress word FIFO with head lookahead and
   one-cycle credit return per popped word */

`default_nettype none
`timescale 1ns/100ps

module ingress_port_buffer (
    input  wire logic              phys_port_clk_ifc,
    input  wire logic              arst_n,

    input  wire logic              wr_valid,
    input  wire router_pkg::word_t wr_data,
    input  wire logic              wr_last,

    input  wire logic              pop,
    output router_pkg::word_t      head_data,
    output logic                   head_last,
    output logic                   not_empty,

    output logic                   credit
);

    import router_pkg::*;

    word_t     mem_data [ING_FIFO_DEPTH];
    logic      mem_last [ING_FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge phys_port_clk_ifc) begin
        if (wr_valid) begin
            mem_data[wr_ptr[FIFO_AW-1:0]] <= wr_data;
            mem_last[wr_ptr[FIFO_AW-1:0]] <= wr_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and credit return

    // Sender credits guarantee no write ever lands on a full buffer
    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Lines up with the popped word on the core bus
            credit <= pop;
        end
    end

    // Full leaves only the wrap bits different, so this stays set
    assign not_empty = (wr_ptr != rd_ptr);

    assign head_data = mem_data[rd_ptr[FIFO_AW-1:0]];
    assign head_last = mem_last[rd_ptr[FIFO_AW-1:0]];

endmodule

`default_nettype wire

// File: rtl/packet_arbiter.sv
/* Round-robin packet arbiter driving the shared core bus,
   grant held from first word until the last word pops */

`default_nettype none
`timescale 1ns/100ps

module packet_arbiter (
    input  wire logic                 phys_port_clk_ifc,
    input  wire logic                 arst_n,

    input  wire logic                 not_empty        [router_pkg::NUM_PORTS],
    input  wire router_pkg::word_t    head_data        [router_pkg::NUM_PORTS],
    input  wire logic                 head_last        [router_pkg::NUM_PORTS],
    input  wire logic                 egr_credit_avail [router_pkg::NUM_PORTS],
    output logic                      pop              [router_pkg::NUM_PORTS],

    output logic                      bus_valid,
    output router_pkg::word_t         bus_data,
    output logic                      bus_last,
    output router_pkg::port_idx_t     bus_port
);

    import router_pkg::*;

    arb_state_t state;
    port_idx_t  grant_port;     // Current grant, last granted while idle
    port_idx_t  cand_port;
    port_idx_t  rr_idx;
    logic       cand_found;
    port_idx_t  cur_port;
    logic       pop_en;

    // First non-empty port after the last grant, wrapping back to it
    always_comb begin
        cand_found = 1'b0;
        cand_port  = grant_port;
        rr_idx     = grant_port;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            rr_idx = grant_port + port_idx_t'(i);
            if (!cand_found && not_empty[rr_idx]) begin
                cand_found = 1'b1;
                cand_port  = rr_idx;
            end
        end
    end

    // First word goes out in the same cycle the grant is taken
    assign cur_port = (state == ARB_IDLE) ? cand_port : grant_port;
    assign pop_en   = not_empty[cur_port] && egr_credit_avail[cur_port];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            pop[p] = pop_en && (cur_port == port_idx_t'(p));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ARB_IDLE;
            grant_port <= port_idx_t'(NUM_PORTS - 1);
            bus_valid  <= 1'b0;
        end else begin
            bus_valid <= pop_en;
            case (state)
                ARB_IDLE: begin
                    if (cand_found) begin
                        grant_port <= cand_port;
                        // Single-word packet finishes without leaving idle
                        if (!(pop_en && head_last[cand_port])) begin
                            state <= ARB_PACKET;
                        end
                    end
                end
                ARB_PACKET: begin
                    if (pop_en && head_last[grant_port]) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // Core bus payload
    always_ff @(posedge phys_port_clk_ifc) begin
        if (pop_en) begin
            bus_data <= head_data[cur_port];
            bus_last <= head_last[cur_port];
            bus_port <= cur_port;
        end
    end

endmodule

`default_nettype wire

// File: rtl/egress_port_stage.sv
/* Egress output registers per port and egress credit counters
   feeding credit availability back to the arbiter */

`default_nettype none
`timescale 1ns/100ps

module egress_port_stage (
    input  wire logic                  phys_port_clk_ifc,
    input  wire logic                  arst_n,

    input  wire logic                  bus_valid,
    input  wire router_pkg::word_t     bus_data,
    input  wire logic                  bus_last,
    input  wire router_pkg::port_idx_t bus_port,

    input  wire logic                  egr_credit       [router_pkg::NUM_PORTS],
    output logic                       egr_valid        [router_pkg::NUM_PORTS],
    output router_pkg::word_t          egr_data         [router_pkg::NUM_PORTS],
    output logic                       egr_last         [router_pkg::NUM_PORTS],

    output logic                       egr_credit_avail [router_pkg::NUM_PORTS]
);

    import router_pkg::*;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        logic        send;
        credit_cnt_t credit_cnt;

        assign send = bus_valid && (bus_port == port_idx_t'(p));

        ////////////////////////////////////////////////////////////////////////
        // Valid and credit count

        always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
            if (!arst_n) begin
                egr_valid[p] <= 1'b0;
                credit_cnt   <= credit_cnt_t'(EGR_CREDITS);
            end else begin
                egr_valid[p] <= send;
                case ({send, egr_credit[p]})
                    2'b10: begin
                        credit_cnt <= credit_cnt - 1'b1;
                    end
                    2'b01: begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                    default: begin
                        credit_cnt <= credit_cnt;
                    end
                endcase
            end
        end

        // Payload
        always_ff @(posedge phys_port_clk_ifc) begin
            if (send) begin
                egr_data[p] <= bus_data;
                egr_last[p] <= bus_last;
            end
        end

        // A word already on the core bus has claimed one credit
        assign egr_credit_avail[p] = send ? (credit_cnt > credit_cnt_t'(1))
                                          : (credit_cnt != '0);

    end

endmodule

`default_nettype wire

// File: rtl/packet_counters.sv
/* Ingress and egress packet counters per port with a
   registered read port */

`default_nettype none
`timescale 1ns/100ps

module packet_counters (
    input  wire logic                  phys_port_clk_ifc,
    input  wire logic                  arst_n,

    input  wire logic                  ing_valid [router_pkg::NUM_PORTS],
    input  wire logic                  ing_last  [router_pkg::NUM_PORTS],
    input  wire logic                  egr_valid [router_pkg::NUM_PORTS],
    input  wire logic                  egr_last  [router_pkg::NUM_PORTS],

    input  wire router_pkg::port_idx_t cnt_sel,
    output router_pkg::pkt_cnt_t       ing_pkt_cnt,
    output router_pkg::pkt_cnt_t       egr_pkt_cnt
);

    import router_pkg::*;

    pkt_cnt_t ing_cnt [NUM_PORTS];
    pkt_cnt_t egr_cnt [NUM_PORTS];

    // One count per last word, wrapping at the counter width
    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            ing_cnt     <= '{default: '0};
            egr_cnt     <= '{default: '0};
            ing_pkt_cnt <= '0;
            egr_pkt_cnt <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (ing_valid[p] && ing_last[p]) begin
                    ing_cnt[p] <= ing_cnt[p] + 1'b1;
                end
                if (egr_valid[p] && egr_last[p]) begin
                    egr_cnt[p] <= egr_cnt[p] + 1'b1;
                end
            end
            // Read port
            ing_pkt_cnt <= ing_cnt[cnt_sel];
            egr_pkt_cnt <= egr_cnt[cnt_sel];
        end
    end

endmodule

`default_nettype wire

// File: rtl/echo_router.sv
/* Echo router top with ingress buffers, packet arbiter,
   egress stage and packet counters */

`default_nettype none
`timescale 1ns/100ps

module echo_router (
    input  wire logic                  phys_port_clk_ifc,
    input  wire logic                  arst_n,

    input  wire logic                  ing_valid  [router_pkg::NUM_PORTS],
    input  wire router_pkg::word_t     ing_data   [router_pkg::NUM_PORTS],
    input  wire logic                  ing_last   [router_pkg::NUM_PORTS],
    output wire logic                  ing_credit [router_pkg::NUM_PORTS],

    output wire logic                  egr_valid  [router_pkg::NUM_PORTS],
    output wire router_pkg::word_t     egr_data   [router_pkg::NUM_PORTS],
    output wire logic                  egr_last   [router_pkg::NUM_PORTS],
    input  wire logic                  egr_credit [router_pkg::NUM_PORTS],

    input  wire router_pkg::port_idx_t cnt_sel,
    output wire router_pkg::pkt_cnt_t  ing_pkt_cnt,
    output wire router_pkg::pkt_cnt_t  egr_pkt_cnt
);

    import router_pkg::*;

    wire logic      not_empty        [NUM_PORTS];
    wire word_t     head_data        [NUM_PORTS];
    wire logic      head_last        [NUM_PORTS];
    wire logic      pop              [NUM_PORTS];
    wire logic      egr_credit_avail [NUM_PORTS];

    // Core bus
    wire logic      bus_valid;
    wire word_t     bus_data;
    wire logic      bus_last;
    wire port_idx_t bus_port;

    ////////////////////////////////////////////////////////////////////////////
    // Ingress buffers

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ing
        ingress_port_buffer u_ing_buf (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .arst_n            (arst_n),
            .wr_valid          (ing_valid[p]),
            .wr_data           (ing_data[p]),
            .wr_last           (ing_last[p]),
            .pop               (pop[p]),
            .head_data         (head_data[p]),
            .head_last         (head_last[p]),
            .not_empty         (not_empty[p]),
            .credit            (ing_credit[p])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration and egress

    packet_arbiter u_arbiter (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .arst_n            (arst_n),
        .not_empty         (not_empty),
        .head_data         (head_data),
        .head_last         (head_last),
        .egr_credit_avail  (egr_credit_avail),
        .pop               (pop),
        .bus_valid         (bus_valid),
        .bus_data          (bus_data),
        .bus_last          (bus_last),
        .bus_port          (bus_port)
    );

    egress_port_stage u_egress (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .arst_n            (arst_n),
        .bus_valid         (bus_valid),
        .bus_data          (bus_data),
        .bus_last          (bus_last),
        .bus_port          (bus_port),
        .egr_credit        (egr_credit),
        .egr_valid         (egr_valid),
        .egr_data          (egr_data),
        .egr_last          (egr_last),
        .egr_credit_avail  (egr_credit_avail)
    );

    packet_counters u_counters (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .arst_n            (arst_n),
        .ing_valid         (ing_valid),
        .ing_last          (ing_last),
        .egr_valid         (egr_valid),
        .egr_last          (egr_last),
        .cnt_sel           (cnt_sel),
        .ing_pkt_cnt       (ing_pkt_cnt),
        .egr_pkt_cnt       (egr_pkt_cnt)
    );

endmodule

`default_nettype wire

// File: verif/router_props.sv
/* Protocol assertions for the echo router and their bind
   into echo_router */

`default_nettype none
`timescale 1ns/100ps

module router_props (
    input wire logic phys_port_clk_ifc,
    input wire logic arst_n,
    input wire logic ing_valid  [router_pkg::NUM_PORTS],
    input wire logic ing_credit [router_pkg::NUM_PORTS],
    input wire logic egr_valid  [router_pkg::NUM_PORTS],
    input wire logic egr_last   [router_pkg::NUM_PORTS],
    input wire logic egr_credit [router_pkg::NUM_PORTS]
);

    import router_pkg::*;

    logic      violation = 1'b0;
    int        egr_held [NUM_PORTS];
    int        ing_out  [NUM_PORTS];
    logic      pkt_open;
    port_idx_t open_port;

    function automatic void note_failure(input string what);
        $error("%s", what);
        violation = 1'b1;
    endfunction

    // Mirrors of both credit loops and the packet open on egress
    always_ff @(posedge phys_port_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            egr_held  <= '{default: EGR_CREDITS};
            ing_out   <= '{default: 0};
            pkt_open  <= 1'b0;
            open_port <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                egr_held[p] <= egr_held[p] + int'(egr_credit[p]) - int'(egr_valid[p]);
                ing_out[p]  <= ing_out[p] + int'(ing_valid[p]) - int'(ing_credit[p]);
                if (egr_valid[p]) begin
                    pkt_open  <= !egr_last[p];
                    open_port <= port_idx_t'(p);
                end
            end
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        a_egr_credit: assert property (@(posedge phys_port_clk_ifc) disable iff (!arst_n)
            egr_valid[p] |-> egr_held[p] > 0)
            else note_failure($sformatf("Port %0d sent an egress word without credit", p));
        // A credit with no word behind it drives the count below zero
        a_ing_window: assert property (@(posedge phys_port_clk_ifc) disable iff (!arst_n)
            ing_out[p] >= 0 && ing_out[p] <= ING_FIFO_DEPTH)
            else note_failure($sformatf("Port %0d has a bad unreturned word count", p));
        // Packets leave whole, one source at a time
        a_echo_order: assert property (@(posedge phys_port_clk_ifc) disable iff (!arst_n)
            egr_valid[p] |-> (!pkt_open || open_port == port_idx_t'(p)))
            else note_failure($sformatf("Port %0d cut into another packet", p));
    end

endmodule

bind echo_router router_props u_props (.*);

`default_nettype wire

// File: verif/router_tb_clock.sv
/* Testbench clock and power-on reset */

`default_nettype none
`timescale 1ns/100ps

module router_tb_clock (
    output logic phys_port_clk_ifc,
    output logic arst_n
);

    localparam real HALF_PERIOD  = 4.0;
    localparam int  RESET_CYCLES = 8;

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #(HALF_PERIOD) phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    // Release shortly after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge phys_port_clk_ifc);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/router_tb.sv
/* Echo router testbench with per-port senders and receivers,
   scoreboard queues and checking assertions */

`default_nettype none
`timescale 1ns/100ps

module router_tb;

    import router_pkg::*;

    localparam int          PKTS_PER_PORT  = 6;
    localparam int          MIN_LEN        = 1;
    localparam int          MAX_LEN        = 12;
    localparam logic [15:0] LFSR_SEED      = 16'd87;
    localparam int          RESET_TIMEOUT  = 64;
    localparam int          CREDIT_TIMEOUT = 2000;
    localparam int          DRAIN_TIMEOUT  = 5000;
    localparam int          STALL_CYCLES   = 40;

    logic          phys_port_clk_ifc;
    logic          arst_n;
    logic          ing_valid  [NUM_PORTS];
    word_t         ing_data   [NUM_PORTS];
    logic          ing_last   [NUM_PORTS];
    wire logic     ing_credit [NUM_PORTS];
    wire logic     egr_valid  [NUM_PORTS];
    wire word_t    egr_data   [NUM_PORTS];
    wire logic     egr_last   [NUM_PORTS];
    logic          egr_credit [NUM_PORTS];
    port_idx_t     cnt_sel;
    wire pkt_cnt_t ing_pkt_cnt;
    wire pkt_cnt_t egr_pkt_cnt;

    word_t       stim_data [NUM_PORTS][$];
    logic        stim_last [NUM_PORTS][$];
    word_t       exp_data  [NUM_PORTS][$];
    logic        exp_last  [NUM_PORTS][$];
    int          ing_credits [NUM_PORTS];
    int          owed        [NUM_PORTS];
    int          rx_words    [NUM_PORTS];
    int          pkts_sent   [NUM_PORTS];
    logic        hold_credit [NUM_PORTS];
    logic [15:0] lfsr;

    router_tb_clock u_clock (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .arst_n            (arst_n)
    );

    echo_router dut (.*);

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                            test, expected, actual));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic make_packet(input int p, input int len);
        for (int w = 0; w < len; w++) begin
            stim_data[p].push_back(take_bits(32));
            stim_last[p].push_back(w == len - 1);
        end
        pkts_sent[p]++;
    endtask

    task automatic send_packets(input int p);
        int guard;
        while (stim_data[p].size() > 0) begin
            guard = 0;
            while (ing_credits[p] == 0) begin
                ing_valid[p] = 1'b0;
                @(posedge phys_port_clk_ifc);
                #1;
                guard++;
                if (guard > CREDIT_TIMEOUT) begin
                    abort_run($sformatf("Port %0d never got an ingress credit back", p));
                end
            end
            ing_valid[p] = 1'b1;
            ing_data[p]  = stim_data[p].pop_front();
            ing_last[p]  = stim_last[p].pop_front();
            exp_data[p].push_back(ing_data[p]);
            exp_last[p].push_back(ing_last[p]);
            @(posedge phys_port_clk_ifc);
            #1;
        end
        ing_valid[p] = 1'b0;
    endtask

    function automatic bit drained();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_data[p].size() != 0 || owed[p] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Waits for idle traffic, then checks credits and counters
    task automatic check_idle(input string test);
        int guard;
        guard = 0;
        while (!drained()) begin
            @(posedge phys_port_clk_ifc);
            #1;
            guard++;
            if (guard > DRAIN_TIMEOUT) begin
                abort_run($sformatf("Traffic never drained in %s", test));
            end
        end
        repeat (4) @(posedge phys_port_clk_ifc);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (ing_credits[p] == ING_FIFO_DEPTH)
                else report_mismatch($sformatf("%s credits port %0d", test, p),
                                     ING_FIFO_DEPTH, ing_credits[p]);
            cnt_sel = port_idx_t'(p);
            @(posedge phys_port_clk_ifc);
            @(negedge phys_port_clk_ifc);
            assert (ing_pkt_cnt == pkt_cnt_t'(pkts_sent[p]))
                else report_mismatch($sformatf("%s ing_pkt_cnt port %0d", test, p),
                                     pkts_sent[p], ing_pkt_cnt);
            assert (egr_pkt_cnt == pkt_cnt_t'(pkts_sent[p]))
                else report_mismatch($sformatf("%s egr_pkt_cnt port %0d", test, p),
                                     pkts_sent[p], egr_pkt_cnt);
            @(posedge phys_port_clk_ifc);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitors and receivers

    always @(negedge phys_port_clk_ifc) begin
        if (dut.u_props.violation) begin
            abort_run("A protocol assertion in router_props failed");
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (arst_n) begin
                ing_credits[p] = ing_credits[p] + int'(ing_credit[p]) - int'(ing_valid[p]);
            end
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_rx
        always @(negedge phys_port_clk_ifc) begin
            if (arst_n && egr_valid[p]) begin
                assert (exp_data[p].size() != 0)
                    else abort_run($sformatf("Port %0d sent a word nobody sent in", p));
                assert (egr_data[p] == exp_data[p][0])
                    else report_mismatch($sformatf("echo data port %0d", p),
                                         exp_data[p][0], egr_data[p]);
                assert (egr_last[p] == exp_last[p][0])
                    else report_mismatch($sformatf("echo last port %0d", p),
                                         exp_last[p][0], egr_last[p]);
                void'(exp_data[p].pop_front());
                void'(exp_last[p].pop_front());
                rx_words[p]++;
                owed[p]++;
            end
        end

        // One credit back per cycle unless held
        always @(posedge phys_port_clk_ifc) begin
            #1;
            if (owed[p] > 0 && !hold_credit[p]) begin
                egr_credit[p] = 1'b1;
                owed[p]--;
            end else begin
                egr_credit[p] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int guard;
        int base [NUM_PORTS];
        lfsr    = LFSR_SEED;
        cnt_sel = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ing_valid[p]   = 1'b0;
            ing_data[p]    = '0;
            ing_last[p]    = 1'b0;
            egr_credit[p]  = 1'b0;
            hold_credit[p] = 1'b0;
            ing_credits[p] = ING_FIFO_DEPTH;
            owed[p]        = 0;
            rx_words[p]    = 0;
            pkts_sent[p]   = 0;
        end
        guard = 0;
        while (arst_n !== 1'b1) begin
            @(posedge phys_port_clk_ifc);
            guard++;
            if (guard > RESET_TIMEOUT) begin
                abort_run("Reset was never released");
            end
        end
        #1;

        // Quiet outputs after reset
        repeat (4) begin
            @(negedge phys_port_clk_ifc);
            for (int p = 0; p < NUM_PORTS; p++) begin
                assert (egr_valid[p] === 1'b0)
                    else report_mismatch($sformatf("reset egr_valid port %0d", p), 0, egr_valid[p]);
                assert (ing_credit[p] === 1'b0)
                    else report_mismatch($sformatf("reset ing_credit port %0d", p), 0, ing_credit[p]);
            end
        end
        @(posedge phys_port_clk_ifc);
        #1;
        check_idle("reset");

        // Echo integrity, all ports at once
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < PKTS_PER_PORT; k++) begin
                make_packet(p, MIN_LEN + int'(take_bits(4)) % (MAX_LEN - MIN_LEN + 1));
            end
        end
        fork
            send_packets(0);
            send_packets(1);
            send_packets(2);
            send_packets(3);
        join
        check_idle("echo_integrity");

        // Back-pressure on port 2 with the others queued behind it
        hold_credit[2] = 1'b1;
        base = rx_words;
        make_packet(2, MAX_LEN);
        make_packet(0, MIN_LEN + int'(take_bits(4)) % (MAX_LEN - MIN_LEN + 1));
        make_packet(1, MIN_LEN + int'(take_bits(4)) % (MAX_LEN - MIN_LEN + 1));
        make_packet(3, MIN_LEN + int'(take_bits(4)) % (MAX_LEN - MIN_LEN + 1));
        fork
            send_packets(2);
            begin
                repeat (3) @(posedge phys_port_clk_ifc);
                #1;
                fork
                    send_packets(0);
                    send_packets(1);
                    send_packets(3);
                join
            end
        join
        repeat (STALL_CYCLES) @(posedge phys_port_clk_ifc);
        #1;
        assert (rx_words[2] - base[2] <= EGR_CREDITS)
            else report_mismatch("backpressure words on port 2 (at most)",
                                 EGR_CREDITS, rx_words[2] - base[2]);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (p == 2 || rx_words[p] == base[p])
                else report_mismatch($sformatf("backpressure hold port %0d", p),
                                     base[p], rx_words[p]);
        end
        hold_credit[2] = 1'b0;
        check_idle("backpressure");

        if (dut.u_props.violation) begin
            abort_run("A protocol assertion in router_props failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/router_pkg.sv
rtl/ingress_port_buffer.sv
rtl/packet_arbiter.sv
rtl/egress_port_stage.sv
rtl/packet_counters.sv
rtl/echo_router.sv
verif/router_props.sv
verif/router_tb_clock.sv
verif/router_tb.sv
